// ==== design/cpu_types_pkg.sv ====
// ISA-level definitions for the five-stage core.
// Word and register index types, opcode and function code encodings
// and the internal ALU operation set. Reference by package-scoped name.

package cpu_types_pkg;

  // --------------------------------------------------------------------------
  // basic widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // --------------------------------------------------------------------------
  // instruction encodings
  // --------------------------------------------------------------------------
  // primary opcode, bits 31:26
  // SLT has no opcode of its own, it is an RTYPE function
  typedef enum logic [5:0] {
    RTYPE = 6'd0,
    J     = 6'd2,
    BEQ   = 6'd4,
    ADDIU = 6'd9,
    ORI   = 6'd13,
    LUI   = 6'd15,
    LW    = 6'd35,
    SW    = 6'd43,
    HALT  = 6'd63
  } opcode_t;

  // function field of RTYPE, bits 5:0
  typedef enum logic [5:0] {
    ADDU = 6'd33,
    SUBU = 6'd35,
    AND  = 6'd36,
    OR   = 6'd37,
    SLT  = 6'd42
  } funct_t;

  // ALU operation chosen in decode
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5
  } aluop_t;

  // --------------------------------------------------------------------------
  // program counter
  // --------------------------------------------------------------------------
  // first fetch address after reset
  localparam word_t PC_INIT = 32'h0000_0000;
  // sequential step between instructions
  localparam word_t LINK_STRIDE = 32'd4;

endpackage

// ==== design/pipe_regs_pkg.sv ====
// Bundles carried between the pipeline stages.
// Stage registers, the writeback port of the register file, the
// execute redirect and the data-memory request of the core.

package pipe_regs_pkg;

  // fetch/decode register
  typedef struct packed {
    logic                  valid;
    cpu_types_pkg::word_t  instr;
    cpu_types_pkg::word_t  pc_plus4;
  } fetch_decode_t;

  // decode/execute register
  typedef struct packed {
    logic                   valid;
    cpu_types_pkg::aluop_t  aluop;
    // second ALU operand is the extended immediate
    logic                   alu_src;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch;
    logic                   jump;
    logic                   halt;
    cpu_types_pkg::regbits_t dest;
    cpu_types_pkg::word_t   rdat1;
    cpu_types_pkg::word_t   rdat2;
    cpu_types_pkg::word_t   ext_imm;
    cpu_types_pkg::word_t   jump_target;
    cpu_types_pkg::word_t   pc_plus4;
  } decode_exec_t;

  // execute/memory register
  typedef struct packed {
    logic                    valid;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic                    halt;
    cpu_types_pkg::regbits_t dest;
    cpu_types_pkg::word_t    alu_out;
    cpu_types_pkg::word_t    store_data;
  } exec_mem_t;

  // memory/writeback register, wdat already muxed
  typedef struct packed {
    logic                    valid;
    logic                    reg_write;
    logic                    halt;
    cpu_types_pkg::regbits_t dest;
    cpu_types_pkg::word_t    wdat;
  } mem_wrb_t;

  // register file write port
  typedef struct packed {
    logic                    wen;
    cpu_types_pkg::regbits_t wsel;
    cpu_types_pkg::word_t    wdat;
  } reg_write_t;

  // taken branch or jump from execute
  typedef struct packed {
    logic                 taken;
    cpu_types_pkg::word_t target;
  } redirect_t;

  // data-memory request, one-cycle strobes
  typedef struct packed {
    logic                 ren;
    logic                 wen;
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t store;
  } dmem_req_t;

endpackage

// ==== design/register_file.sv ====
// 32 x 32-bit register file for the decode stage.
// Two combinational read ports and one write port from writeback.
// Register zero always reads zero; a same-cycle write is passed
// through to the reads.

`timescale 1ns/10ps

module register_file (
  input  logic                      CLK,
  input  logic                      nRST,
  input  pipe_regs_pkg::reg_write_t wb,
  input  cpu_types_pkg::regbits_t   rsel1,
  input  cpu_types_pkg::regbits_t   rsel2,
  output cpu_types_pkg::word_t      rdat1,
  output cpu_types_pkg::word_t      rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && wb.wsel != '0) begin
      regs[wb.wsel] <= wb.wdat;
    end
  end

  // read ports, zero first then bypass of the write in flight
  always_comb begin
    if (rsel1 == '0) begin
      rdat1 = '0;
    end else if (wb.wen && wb.wsel == rsel1) begin
      rdat1 = wb.wdat;
    end else begin
      rdat1 = regs[rsel1];
    end
    if (rsel2 == '0) begin
      rdat2 = '0;
    end else if (wb.wen && wb.wsel == rsel2) begin
      rdat2 = wb.wdat;
    end else begin
      rdat2 = regs[rsel2];
    end
  end

endmodule

// ==== design/fetch_stage.sv ====
// Fetch stage of the pipelined core.
// Holds the PC, addresses instruction memory combinationally and
// registers the returned word for decode. A taken redirect from
// execute loads the new PC and empties the fetch/decode slot.

`timescale 1ns/10ps

module fetch_stage (
  input  logic                        CLK,
  input  logic                        nRST,
  input  pipe_regs_pkg::redirect_t    redirect,
  output cpu_types_pkg::word_t        imem_addr,
  input  cpu_types_pkg::word_t        imem_load,
  output pipe_regs_pkg::fetch_decode_t fd
);

  cpu_types_pkg::word_t pc;
  cpu_types_pkg::word_t pc_plus4;
  cpu_types_pkg::word_t next_pc;

  assign pc_plus4  = pc + cpu_types_pkg::LINK_STRIDE;
  // redirect wins over sequential fetch
  assign next_pc   = redirect.taken ? redirect.target : pc_plus4;
  assign imem_addr = pc;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= cpu_types_pkg::PC_INIT;
    end else begin
      pc <= next_pc;
    end
  end

  // --------------------------------------------------------------------------
  // fetch/decode register
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      fd <= '0;
    end else begin
      // word fetched under a redirect is on the wrong path
      fd.valid    <= !redirect.taken;
      fd.instr    <= imem_load;
      fd.pc_plus4 <= pc_plus4;
    end
  end

  // branch offsets and jump targets are word multiples
  pc_aligned: assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00)
    else $error("fetch PC not word aligned: %h", pc);

endmodule

// ==== design/decode_stage.sv ====
// Decode stage of the pipelined core.
// Turns opcode and function code into ALU operation and control bits,
// extends the immediate, reads the register file and registers the
// bundle for execute. A redirect from execute squashes the slot.

`timescale 1ns/10ps

module decode_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  pipe_regs_pkg::fetch_decode_t fd,
  input  pipe_regs_pkg::reg_write_t    wb,
  input  pipe_regs_pkg::redirect_t     redirect,
  output pipe_regs_pkg::decode_exec_t  de
);

  cpu_types_pkg::opcode_t  opcode;
  cpu_types_pkg::funct_t   funct;
  cpu_types_pkg::regbits_t rs;
  cpu_types_pkg::regbits_t rt;
  cpu_types_pkg::regbits_t rd;
  logic [15:0]             imm;
  cpu_types_pkg::word_t    rdat1;
  cpu_types_pkg::word_t    rdat2;
  pipe_regs_pkg::decode_exec_t ctrl;
  // control bits not stored in the bundle
  logic                    sign_ext;
  logic                    rd_dest;
  logic                    illegal;

  // instruction fields
  assign opcode = cpu_types_pkg::opcode_t'(fd.instr[31:26]);
  assign funct  = cpu_types_pkg::funct_t'(fd.instr[5:0]);
  assign rs     = fd.instr[25:21];
  assign rt     = fd.instr[20:16];
  assign rd     = fd.instr[15:11];
  assign imm    = fd.instr[15:0];

  register_file rf_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .wb    (wb),
    .rsel1 (rs),
    .rsel2 (rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // --------------------------------------------------------------------------
  // control decode
  // --------------------------------------------------------------------------
  always_comb begin
    ctrl     = '0;
    ctrl.aluop = cpu_types_pkg::ALU_ADD;
    sign_ext = 1'b0;
    rd_dest  = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      cpu_types_pkg::RTYPE: begin
        ctrl.reg_write = 1'b1;
        rd_dest        = 1'b1;
        case (funct)
          cpu_types_pkg::ADDU: ctrl.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: ctrl.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  ctrl.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   ctrl.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::SLT:  ctrl.aluop = cpu_types_pkg::ALU_SLT;
          default: begin
            // unsupported function, no register write
            ctrl.reg_write = 1'b0;
            illegal        = 1'b1;
          end
        endcase
      end
      cpu_types_pkg::ADDIU: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        sign_ext       = 1'b1;
      end
      cpu_types_pkg::ORI: begin
        ctrl.aluop     = cpu_types_pkg::ALU_OR;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_types_pkg::LUI: begin
        ctrl.aluop     = cpu_types_pkg::ALU_LUI;
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_types_pkg::LW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        sign_ext       = 1'b1;
      end
      cpu_types_pkg::SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        sign_ext       = 1'b1;
      end
      cpu_types_pkg::BEQ: begin
        ctrl.aluop  = cpu_types_pkg::ALU_SUB;
        ctrl.branch = 1'b1;
        sign_ext    = 1'b1;
      end
      cpu_types_pkg::J:    ctrl.jump = 1'b1;
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default:             illegal   = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------------
  // decode/execute register
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      de <= '0;
    end else begin
      de       <= ctrl;
      // younger than a taken branch, drop it
      de.valid <= fd.valid && !redirect.taken;
      de.dest  <= rd_dest ? rd : rt;
      de.rdat1 <= rdat1;
      de.rdat2 <= rdat2;
      de.ext_imm <= sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
      // J target: region bits of pc+4 with the word index
      de.jump_target <= {fd.pc_plus4[31:28], fd.instr[25:0], 2'b00};
      de.pc_plus4    <= fd.pc_plus4;
    end
  end

  known_opcode: assert property (@(posedge CLK) disable iff (!nRST) fd.valid |-> !illegal)
    else $error("unknown instruction %h at %h", fd.instr, fd.pc_plus4 - 32'd4);

endmodule

// ==== design/exec_stage.sv ====
// Execute stage of the pipelined core.
// ALU on the decoded operands, BEQ and J resolution with a combinational
// redirect back to fetch and decode, and the execute/memory register.

`timescale 1ns/10ps

module exec_stage (
  input  logic                        CLK,
  input  logic                        nRST,
  input  pipe_regs_pkg::decode_exec_t de,
  output pipe_regs_pkg::redirect_t    redirect,
  output pipe_regs_pkg::exec_mem_t    em
);

  cpu_types_pkg::word_t alu_b;
  cpu_types_pkg::word_t alu_out;
  cpu_types_pkg::word_t branch_target;
  logic                 equal;

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------
  assign alu_b = de.alu_src ? de.ext_imm : de.rdat2;

  always_comb begin
    case (de.aluop)
      cpu_types_pkg::ALU_ADD: alu_out = de.rdat1 + alu_b;
      cpu_types_pkg::ALU_SUB: alu_out = de.rdat1 - alu_b;
      cpu_types_pkg::ALU_AND: alu_out = de.rdat1 & alu_b;
      cpu_types_pkg::ALU_OR:  alu_out = de.rdat1 | alu_b;
      // signed compare
      cpu_types_pkg::ALU_SLT: alu_out = {31'd0, $signed(de.rdat1) < $signed(alu_b)};
      // immediate into the upper half
      cpu_types_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
      default:                alu_out = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // branch and jump
  // --------------------------------------------------------------------------
  assign equal         = de.rdat1 == de.rdat2;
  // word offset relative to pc+4
  assign branch_target = de.pc_plus4 + {de.ext_imm[29:0], 2'b00};

  always_comb begin
    redirect.taken  = de.valid && (de.jump || (de.branch && equal));
    redirect.target = de.jump ? de.jump_target : branch_target;
  end

  // execute/memory register
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      em <= '0;
    end else begin
      em.valid      <= de.valid;
      em.reg_write  <= de.reg_write;
      em.mem_read   <= de.mem_read;
      em.mem_write  <= de.mem_write;
      em.halt       <= de.halt;
      em.dest       <= de.dest;
      em.alu_out    <= alu_out;
      em.store_data <= de.rdat2;
    end
  end

  // taken only from a live slot, and decode must squash the next one
  redirect_valid: assert property (@(posedge CLK) disable iff (!nRST)
    redirect.taken |-> de.valid ##1 !de.valid)
    else $error("redirect from invalid slot or younger slot not flushed");

endmodule

// ==== design/mem_wrb_stage.sv ====
// Memory and writeback stages of the pipelined core.
// Issues the single-cycle data-memory strobes, captures load data into
// the memory/writeback register, drives the register file write and
// holds the sticky halt flag. Nothing younger than HALT touches memory.

`timescale 1ns/10ps

module mem_wrb_stage (
  input  logic                      CLK,
  input  logic                      nRST,
  input  pipe_regs_pkg::exec_mem_t  em,
  output pipe_regs_pkg::dmem_req_t  dmem_req,
  input  cpu_types_pkg::word_t      dmem_load,
  output pipe_regs_pkg::reg_write_t wb,
  output logic                      halt
);

  pipe_regs_pkg::mem_wrb_t mw;
  // HALT ahead in writeback or already retired
  logic                    draining;
  logic                    live;

  assign draining = halt || (mw.valid && mw.halt);
  assign live     = em.valid && !draining;

  // --------------------------------------------------------------------------
  // data-memory request
  // --------------------------------------------------------------------------
  always_comb begin
    dmem_req.ren   = live && em.mem_read;
    dmem_req.wen   = live && em.mem_write;
    dmem_req.addr  = em.alu_out;
    dmem_req.store = em.store_data;
  end

  // memory/writeback register, load data sampled same cycle
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mw <= '0;
    end else begin
      mw.valid     <= live;
      mw.reg_write <= em.reg_write;
      mw.halt      <= em.halt;
      mw.dest      <= em.dest;
      mw.wdat      <= em.mem_read ? dmem_load : em.alu_out;
    end
  end

  // --------------------------------------------------------------------------
  // writeback
  // --------------------------------------------------------------------------
  always_comb begin
    wb.wen  = mw.valid && mw.reg_write;
    wb.wsel = mw.dest;
    wb.wdat = mw.wdat;
  end

  // sticky until reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else begin
      halt <= halt || (mw.valid && mw.halt);
    end
  end

  one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen))
    else $error("dmem read and write strobes together");

endmodule

// ==== design/pipeline_cpu.sv ====
// Top level of the five-stage pipelined core.
// Connects fetch, decode, execute and memory/writeback to the external
// instruction and data memories. Both memories answer in the same cycle.

`timescale 1ns/10ps

module pipeline_cpu (
  input  logic                     CLK,
  input  logic                     nRST,
  output cpu_types_pkg::word_t     imem_addr,
  input  cpu_types_pkg::word_t     imem_load,
  output pipe_regs_pkg::dmem_req_t dmem_req,
  input  cpu_types_pkg::word_t     dmem_load,
  output logic                     halt
);

  // stage-to-stage bundles
  pipe_regs_pkg::fetch_decode_t fd;
  pipe_regs_pkg::decode_exec_t  de;
  pipe_regs_pkg::exec_mem_t     em;
  pipe_regs_pkg::reg_write_t    wb;
  pipe_regs_pkg::redirect_t     redirect;

  fetch_stage fetch_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .redirect  (redirect),
    .imem_addr (imem_addr),
    .imem_load (imem_load),
    .fd        (fd)
  );

  decode_stage decode_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .fd       (fd),
    .wb       (wb),
    .redirect (redirect),
    .de       (de)
  );

  exec_stage exec_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .de       (de),
    .redirect (redirect),
    .em       (em)
  );

  mem_wrb_stage mem_wrb_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .em        (em),
    .dmem_req  (dmem_req),
    .dmem_load (dmem_load),
    .wb        (wb),
    .halt      (halt)
  );

endmodule

// ==== sim/tb_clock.sv ====
// Clock and reset source for the core testbench.
// 20 ns clock; nRST is held low for three rising edges at start-up and
// again each time restart is seen high on a rising edge.

`timescale 1ns/10ps

module tb_clock (
  input  logic restart,
  output logic CLK,
  output logic nRST
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_EDGES = 3;

  logic        rst_n_q   = 1'b0;
  int unsigned low_left  = RESET_EDGES;

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // count down the low phase, release on the last edge
  always @(posedge CLK) begin
    if (restart) begin
      rst_n_q  <= 1'b0;
      low_left <= RESET_EDGES;
    end else if (low_left != 0) begin
      low_left <= low_left - 1;
      if (low_left == 1) begin
        rst_n_q <= 1'b1;
      end
    end
  end

  assign nRST = rst_n_q;

endmodule

// ==== sim/pipeline_cpu_tb.sv ====
// Testbench for the five-stage pipelined core.
// Runs a table of short programs against models of the instruction and
// data memories, then checks the reset state, halt and every store.
// Programs keep two other instructions between producer and consumer.

`timescale 1ns/10ps

module pipeline_cpu_tb;

  localparam int NUM_TESTS     = 7;
  localparam int PROG_WORDS    = 12;
  localparam int MAX_STORES    = 4;
  localparam int IMEM_WORDS    = 16;
  localparam int DMEM_WORDS    = 64;
  localparam int HALT_TIMEOUT  = 200;
  localparam int RESET_TIMEOUT = 10;
  localparam int DRAIN_CYCLES  = 10;
  localparam cpu_types_pkg::word_t HALT_WORD = {cpu_types_pkg::HALT, 26'd0};
  // ADDU r0, r0, r0
  localparam cpu_types_pkg::word_t NOP_WORD  = {6'd0, 20'd0, cpu_types_pkg::ADDU};

  logic                     CLK;
  logic                     nRST;
  logic                     restart = 1'b0;
  cpu_types_pkg::word_t     imem_addr;
  cpu_types_pkg::word_t     imem_load;
  pipe_regs_pkg::dmem_req_t dmem_req;
  cpu_types_pkg::word_t     dmem_load;
  logic                     halt;

  cpu_types_pkg::word_t     imem [IMEM_WORDS];
  cpu_types_pkg::word_t     dmem [DMEM_WORDS];
  cpu_types_pkg::word_t     seed_words [DMEM_WORDS];
  pipe_regs_pkg::dmem_req_t store_log [$];

  // program table
  string                    test_name [NUM_TESTS];
  cpu_types_pkg::word_t     prog [NUM_TESTS][PROG_WORDS];
  int                       prog_len [NUM_TESTS];
  pipe_regs_pkg::dmem_req_t exp_store [NUM_TESTS][MAX_STORES];
  int                       exp_count [NUM_TESTS];

  int                       test_errors;
  int                       tests_failed;

  tb_clock clock_gen_i (
    .restart (restart),
    .CLK     (CLK),
    .nRST    (nRST)
  );

  pipeline_cpu pipeline_cpu_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .imem_addr (imem_addr),
    .imem_load (imem_load),
    .dmem_req  (dmem_req),
    .dmem_load (dmem_load),
    .halt      (halt)
  );

  // --------------------------------------------------------------------------
  // memory models
  // --------------------------------------------------------------------------
  // past the loaded words the core only ever sees HALT
  assign imem_load = (imem_addr < 32'(IMEM_WORDS * 4)) ? imem[imem_addr[5:2]] : HALT_WORD;
  // load data only under the read strobe
  assign dmem_load = dmem_req.ren ? dmem[dmem_req.addr[7:2]] : '0;

  // write strobe sampled at the edge that ends its cycle
  always @(posedge CLK) begin
    if (nRST && dmem_req.wen) begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.store;
      store_log.push_back(dmem_req);
    end
  end

  function automatic cpu_types_pkg::word_t xorshift32(cpu_types_pkg::word_t x);
    cpu_types_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------------------------------------------------------------
  // instruction encoders and table helpers
  // --------------------------------------------------------------------------
  function automatic cpu_types_pkg::word_t asm_r(cpu_types_pkg::funct_t f,
                                                 int rd, int rs, int rt);
    return {cpu_types_pkg::RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
  endfunction

  function automatic cpu_types_pkg::word_t asm_i(cpu_types_pkg::opcode_t op,
                                                 int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic cpu_types_pkg::word_t asm_j(int index);
    return {cpu_types_pkg::J, 26'(index)};
  endfunction

  task automatic emit(int t, cpu_types_pkg::word_t instr);
    prog[t][prog_len[t]] = instr;
    prog_len[t]++;
  endtask

  task automatic expect_store(int t, cpu_types_pkg::word_t addr,
                              cpu_types_pkg::word_t data);
    // ren, wen, addr, store
    exp_store[t][exp_count[t]] = {1'b0, 1'b1, addr, data};
    exp_count[t]++;
  endtask

  task automatic build_table();
    int t;
    for (t = 0; t < NUM_TESTS; t++) begin
      prog_len[t]  = 0;
      exp_count[t] = 0;
    end
    // signed and unsigned arithmetic on 100 and -7
    test_name[0] = "rtype_arith";
    emit(0, asm_i(cpu_types_pkg::ADDIU, 1, 0, 100));
    emit(0, asm_i(cpu_types_pkg::ADDIU, 2, 0, -7));
    emit(0, NOP_WORD);
    emit(0, NOP_WORD);
    emit(0, asm_r(cpu_types_pkg::ADDU, 3, 1, 2));
    emit(0, asm_r(cpu_types_pkg::SUBU, 4, 1, 2));
    emit(0, asm_r(cpu_types_pkg::SLT, 5, 2, 1));
    emit(0, asm_r(cpu_types_pkg::SLT, 6, 1, 2));
    emit(0, asm_i(cpu_types_pkg::SW, 3, 0, 'h10));
    emit(0, asm_i(cpu_types_pkg::SW, 4, 0, 'h14));
    emit(0, asm_i(cpu_types_pkg::SW, 5, 0, 'h18));
    emit(0, asm_i(cpu_types_pkg::SW, 6, 0, 'h1C));
    expect_store(0, 32'h10, 32'd93);
    expect_store(0, 32'h14, 32'd107);
    // -7 < 100 only when compared signed
    expect_store(0, 32'h18, 32'd1);
    expect_store(0, 32'h1C, 32'd0);
    // AND and OR of a zero-extended and a sign-extended value
    test_name[1] = "rtype_logic";
    emit(1, asm_i(cpu_types_pkg::ORI, 1, 0, 'h8F0F));
    emit(1, asm_i(cpu_types_pkg::ADDIU, 2, 0, -256));
    emit(1, NOP_WORD);
    emit(1, asm_i(cpu_types_pkg::SW, 1, 0, 'h28));
    emit(1, asm_r(cpu_types_pkg::AND, 3, 1, 2));
    emit(1, asm_r(cpu_types_pkg::OR, 4, 1, 2));
    emit(1, NOP_WORD);
    emit(1, asm_i(cpu_types_pkg::SW, 3, 0, 'h20));
    emit(1, asm_i(cpu_types_pkg::SW, 4, 0, 'h24));
    expect_store(1, 32'h28, 32'h0000_8F0F);
    expect_store(1, 32'h20, 32'h0000_8F00);
    expect_store(1, 32'h24, 32'hFFFF_FF0F);
    // immediate extension rules
    test_name[2] = "imm_ext";
    emit(2, asm_i(cpu_types_pkg::ADDIU, 1, 0, 'hFFFB));
    emit(2, asm_i(cpu_types_pkg::ORI, 2, 0, 'hFFFB));
    emit(2, asm_i(cpu_types_pkg::LUI, 3, 0, 'h1234));
    emit(2, asm_i(cpu_types_pkg::SW, 1, 0, 'h30));
    emit(2, asm_i(cpu_types_pkg::SW, 2, 0, 'h34));
    emit(2, asm_i(cpu_types_pkg::ORI, 4, 3, 'h5678));
    emit(2, asm_i(cpu_types_pkg::SW, 3, 0, 'h38));
    emit(2, NOP_WORD);
    emit(2, asm_i(cpu_types_pkg::SW, 4, 0, 'h3C));
    expect_store(2, 32'h30, 32'hFFFF_FFFB);
    expect_store(2, 32'h34, 32'h0000_FFFB);
    expect_store(2, 32'h38, 32'h1234_0000);
    expect_store(2, 32'h3C, 32'h1234_5678);
    // copy seeded words via r0 and via a base register with negative offset
    test_name[3] = "load_store";
    emit(3, asm_i(cpu_types_pkg::ADDIU, 4, 0, 'h40));
    emit(3, asm_i(cpu_types_pkg::LW, 1, 0, 'h0));
    emit(3, asm_i(cpu_types_pkg::LW, 2, 0, 'h4));
    emit(3, asm_i(cpu_types_pkg::LW, 3, 4, -4));
    emit(3, asm_i(cpu_types_pkg::SW, 1, 0, 'h80));
    emit(3, asm_i(cpu_types_pkg::SW, 2, 0, 'h84));
    emit(3, asm_i(cpu_types_pkg::SW, 3, 4, 'h48));
    expect_store(3, 32'h80, seed_words[0]);
    expect_store(3, 32'h84, seed_words[1]);
    expect_store(3, 32'h88, seed_words[15]);
    // taken BEQ skips two flushed stores
    test_name[4] = "beq_taken";
    emit(4, asm_i(cpu_types_pkg::ADDIU, 1, 0, 3));
    emit(4, asm_i(cpu_types_pkg::ADDIU, 2, 0, 3));
    emit(4, NOP_WORD);
    emit(4, NOP_WORD);
    emit(4, asm_i(cpu_types_pkg::BEQ, 2, 1, 2));
    emit(4, asm_i(cpu_types_pkg::SW, 1, 0, 'h90));
    emit(4, asm_i(cpu_types_pkg::SW, 2, 0, 'h94));
    emit(4, asm_i(cpu_types_pkg::SW, 1, 0, 'h98));
    expect_store(4, 32'h98, 32'd3);
    // same shape with unequal operands falling through
    test_name[5] = "beq_not_taken";
    emit(5, asm_i(cpu_types_pkg::ADDIU, 1, 0, 3));
    emit(5, asm_i(cpu_types_pkg::ADDIU, 2, 0, -3));
    emit(5, NOP_WORD);
    emit(5, NOP_WORD);
    emit(5, asm_i(cpu_types_pkg::BEQ, 2, 1, 2));
    emit(5, asm_i(cpu_types_pkg::SW, 1, 0, 'hA0));
    emit(5, asm_i(cpu_types_pkg::SW, 2, 0, 'hA4));
    emit(5, asm_i(cpu_types_pkg::SW, 1, 0, 'hA8));
    expect_store(5, 32'hA0, 32'd3);
    expect_store(5, 32'hA4, 32'hFFFF_FFFD);
    expect_store(5, 32'hA8, 32'd3);
    // J to word 5 over two flushed and one skipped store
    test_name[6] = "jump";
    emit(6, asm_i(cpu_types_pkg::ADDIU, 1, 0, 'h55));
    emit(6, asm_j(5));
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hB0));
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hB4));
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hB8));
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hBC));
    // stores behind HALT must never reach memory
    emit(6, HALT_WORD);
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hC0));
    emit(6, asm_i(cpu_types_pkg::SW, 1, 0, 'hC4));
    expect_store(6, 32'hBC, 32'h55);
  endtask

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  function automatic string fmt_req(pipe_regs_pkg::dmem_req_t r);
    return $sformatf("ren=%b wen=%b addr=%h data=%h", r.ren, r.wen, r.addr, r.store);
  endfunction

  task automatic check_store(string label, pipe_regs_pkg::dmem_req_t exp,
                             pipe_regs_pkg::dmem_req_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %s, actual %s", label, fmt_req(exp), fmt_req(act));
      test_errors++;
    end
  endtask

  task automatic check_word(string label, cpu_types_pkg::word_t exp,
                            cpu_types_pkg::word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", label, exp, act);
      test_errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // one table entry
  // --------------------------------------------------------------------------
  task automatic run_test(int t);
    int    i;
    int    cycles;
    int    logged;
    logic  dropped;
    string name;
    name        = test_name[t];
    test_errors = 0;
    dropped     = 1'b0;
    // load memories while the previous program sits halted
    @(posedge CLK);
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] <= (i < prog_len[t]) ? prog[t][i] : HALT_WORD;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] <= seed_words[i];
    end
    store_log.delete();
    restart <= 1'b1;
    @(posedge CLK);
    restart <= 1'b0;
    @(negedge CLK);
    cycles = 0;
    while (!nRST && cycles < RESET_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!nRST) begin
      $display("test %s: reset was never released", name);
      test_errors++;
    end
    // no edge with nRST high yet
    check_word({name, " reset pc"}, cpu_types_pkg::PC_INIT, imem_addr);
    check_word({name, " reset halt/ren/wen"}, '0,
               {29'd0, halt, dmem_req.ren, dmem_req.wen});
    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) begin
      $display("test %s: halt never rose within %0d cycles", name, HALT_TIMEOUT);
      test_errors++;
    end
    // halt must hold and memory must stay quiet
    logged = store_log.size();
    for (i = 0; i < DRAIN_CYCLES; i++) begin
      @(negedge CLK);
      if (!halt) begin
        dropped = 1'b1;
      end
    end
    if (dropped) begin
      $display("test %s: halt fell before the next reset", name);
      test_errors++;
    end
    check_word({name, " stores after halt"}, logged, store_log.size());
    check_word({name, " store count"}, exp_count[t], store_log.size());
    for (i = 0; i < exp_count[t] && i < store_log.size(); i++) begin
      check_store($sformatf("%s store %0d", name, i), exp_store[t][i], store_log[i]);
    end
    if (test_errors == 0) begin
      $display("test %s: ok, %0d stores", name, store_log.size());
    end else begin
      $display("test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    cpu_types_pkg::word_t state;
    int                   i;
    int                   t;
    state = 32'd85;
    for (i = 0; i < DMEM_WORDS; i++) begin
      state         = xorshift32(state);
      seed_words[i] = state;
      dmem[i]       = state;
    end
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = HALT_WORD;
    end
    tests_failed = 0;
    build_table();
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, passed %0d, failed %0d",
             NUM_TESTS, NUM_TESTS - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/cpu_types_pkg.sv
design/pipe_regs_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/mem_wrb_stage.sv
design/pipeline_cpu.sv
sim/tb_clock.sv
sim/pipeline_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

sources:
  - design/cpu_types_pkg.sv
  - design/pipe_regs_pkg.sv
  - design/register_file.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/exec_stage.sv
  - design/mem_wrb_stage.sv
  - design/pipeline_cpu.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/pipeline_cpu_tb.sv
